// File: alu.sv
/* Integer ALU: add, subtract, set-less-than, logic ops and shifts */
`default_nettype none

module alu import ieuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  aluOpT           aluOp,
  output logic [XLEN-1:0] result
);

  // RV64 shifts by up to 63
  localparam int ShW = (XLEN == 64) ? 6 : 5;

  logic [ShW-1:0]  shamt;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            ltS;
  logic            ltU;

  assign shamt = b[ShW-1:0];

  //////////////////////////////////////////////////////////////////////
  // Arithmetic and compare
  //////////////////////////////////////////////////////////////////////

  assign sum  = a + b;
  assign diff = a - b;

  // Signed and unsigned less-than
  assign ltS = $signed(a) < $signed(b);
  assign ltU = a < b;

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (aluOp)
      aluAdd:  result = sum;
      aluSub:  result = diff;
      aluSll:  result = a << shamt;
      aluSlt:  result = XLEN'(ltS);
      aluSltu: result = XLEN'(ltU);
      aluXor:  result = a ^ b;
      aluSrl:  result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      aluSra:  result = $unsigned($signed(a) >>> shamt);
      aluOr:   result = a | b;
      aluAnd:  result = a & b;
      default: result = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: datapath.sv
/*
  Integer datapath: register file read, immediate, Execute operand muxes,
  ALU and the Execute, Memory and Writeback data registers
*/
`default_nettype none

module datapath import ieuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic [31:0]     instrD,
  input  logic [XLEN-1:0] pcD,
  input  immSrcT          immSrcD,
  input  ctrlET           ctrlE,
  input  fwdSelT          forwardAE,
  input  fwdSelT          forwardBE,
  input  logic            regWriteW,
  output regIdxT          rs1E,
  output regIdxT          rs2E,
  output regIdxT          rdM,
  output regIdxT          rdW,
  output logic [XLEN-1:0] resultW
);

  // Decode to Execute payload
  typedef struct packed {
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    regIdxT          rs1;
    regIdxT          rs2;
    regIdxT          rd;
  } exRegT;

  // Result and destination, used for Memory and Writeback
  typedef struct packed {
    logic [XLEN-1:0] result;
    regIdxT          rd;
  } resRegT;

  regIdxT          rs1D, rs2D, rdD;
  logic [XLEN-1:0] rd1D, rd2D, immD;
  exRegT           exD, exE;
  logic [XLEN-1:0] fwdAE, fwdBE;
  logic [XLEN-1:0] srcAE, srcBE;
  logic [XLEN-1:0] aluOutE;
  resRegT          resE, resM, resW;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  // Writes come from Writeback
  regFile #(.XLEN(XLEN)) rf (
    .clk, .rstN, .we(regWriteW), .rs1(rs1D), .rs2(rs2D),
    .rd(resW.rd), .wd(resW.result), .rd1(rd1D), .rd2(rd2D)
  );

  immExtend #(.XLEN(XLEN)) ext (.instr(instrD[31:7]), .immSrc(immSrcD), .imm(immD));

  assign exD = '{rd1: rd1D, rd2: rd2D, imm: immD, pc: pcD,
                 rs1: rs1D, rs2: rs2D, rd: rdD};

  //////////////////////////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////////////////////////

  // Forwarding from Memory or Writeback
  always_comb begin
    case (forwardAE)
      fwdMem:  fwdAE = resM.result;
      fwdWb:   fwdAE = resW.result;
      default: fwdAE = exE.rd1;
    endcase
    case (forwardBE)
      fwdMem:  fwdBE = resM.result;
      fwdWb:   fwdBE = resW.result;
      default: fwdBE = exE.rd2;
    endcase
  end

  // AUIPC uses the PC and OP-IMM the immediate
  assign srcAE = ctrlE.aluSrcA ? exE.pc : fwdAE;
  assign srcBE = ctrlE.aluSrcB ? exE.imm : fwdBE;

  alu #(.XLEN(XLEN)) aluE (.a(srcAE), .b(srcBE), .aluOp(ctrlE.aluOp), .result(aluOutE));

  // LUI bypasses the ALU
  assign resE.result = ctrlE.resultImm ? exE.imm : aluOutE;
  assign resE.rd     = exE.rd;

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exE  <= '0;
      resM <= '0;
      resW <= '0;
    end else begin
      exE  <= exD;
      resM <= resE;
      resW <= resM;
    end
  end

  // Register numbers for the hazard unit
  assign rs1E    = exE.rs1;
  assign rs2E    = exE.rs2;
  assign rdM     = resM.rd;
  assign rdW     = resW.rd;
  assign resultW = resW.result;

endmodule

`default_nettype wire

// File: hazardUnit.sv
/* Forwarding select for the two Execute operands */
`default_nettype none

module hazardUnit import ieuPkg::*; (
  input  regIdxT rs1E,
  input  regIdxT rs2E,
  input  regIdxT rdM,
  input  regIdxT rdW,
  input  logic   regWriteM,
  input  logic   regWriteW,
  output fwdSelT forwardAE,
  output fwdSelT forwardBE
);

  // Memory is younger so it wins over Writeback
  function automatic fwdSelT pickSrc(regIdxT rs, regIdxT rM, regIdxT rW,
                                     logic wrM, logic wrW);
    if (wrM && rM != '0 && rM == rs) return fwdMem;
    else if (wrW && rW != '0 && rW == rs) return fwdWb;
    else return fwdReg;
  endfunction

  // x0 writes never forward
  always_comb forwardAE = pickSrc(rs1E, rdM, rdW, regWriteM, regWriteW);
  always_comb forwardBE = pickSrc(rs2E, rdM, rdW, regWriteM, regWriteW);

endmodule

`default_nettype wire

// File: ieu.sv
/* Integer execution unit top: controller, hazard unit and datapath */
`default_nettype none

module ieu import ieuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,
  input  logic [31:0]     instrD,
  input  logic [XLEN-1:0] pcD,
  output logic            wbValid,
  output regIdxT          wbRd,
  output logic [XLEN-1:0] wbData
);

  immSrcT immSrcD;
  ctrlET  ctrlE;
  logic   regWriteM;
  fwdSelT forwardAE, forwardBE;
  regIdxT rs1E, rs2E, rdM;

  // Writeback ports are the register file write port itself
  intController ctrl (
    .clk, .rstN, .instrValid, .instrD,
    .immSrcD, .ctrlE, .regWriteM, .regWriteW(wbValid)
  );

  hazardUnit hzd (
    .rs1E, .rs2E, .rdM, .rdW(wbRd),
    .regWriteM, .regWriteW(wbValid),
    .forwardAE, .forwardBE
  );

  datapath #(.XLEN(XLEN)) dp (
    .clk, .rstN, .instrD, .pcD, .immSrcD, .ctrlE,
    .forwardAE, .forwardBE, .regWriteW(wbValid),
    .rs1E, .rs2E, .rdM, .rdW(wbRd), .resultW(wbData)
  );

endmodule

`default_nettype wire

// File: ieuPkg.sv
/*
  Shared types of the integer execution unit: register index, ALU op,
  opcode, immediate format, forwarding select and the Execute control struct
*/
`default_nettype none

package ieuPkg;

  //////////////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [4:0] regIdxT;
  typedef logic [3:0] aluOpT;
  typedef logic [1:0] fwdSelT;
  typedef logic [6:0] opcodeT;
  typedef logic       immSrcT;

  // ALU operations, one per OP instruction
  localparam aluOpT aluAdd  = 4'd0;
  localparam aluOpT aluSub  = 4'd1;
  localparam aluOpT aluSll  = 4'd2;
  localparam aluOpT aluSlt  = 4'd3;
  localparam aluOpT aluSltu = 4'd4;
  localparam aluOpT aluXor  = 4'd5;
  localparam aluOpT aluSrl  = 4'd6;
  localparam aluOpT aluSra  = 4'd7;
  localparam aluOpT aluOr   = 4'd8;
  localparam aluOpT aluAnd  = 4'd9;

  // Major opcodes kept in this subset
  localparam opcodeT opOp    = 7'b0110011;
  localparam opcodeT opOpImm = 7'b0010011;
  localparam opcodeT opLui   = 7'b0110111;
  localparam opcodeT opAuipc = 7'b0010111;

  // Immediate formats
  localparam immSrcT immI = 1'b0;
  localparam immSrcT immU = 1'b1;

  // Operand source in Execute
  localparam fwdSelT fwdReg = 2'b00;
  localparam fwdSelT fwdWb  = 2'b01;
  localparam fwdSelT fwdMem = 2'b10;

  // Controls consumed in Execute
  typedef struct packed {
    aluOpT aluOp;
    logic  aluSrcA;    // PC in place of rs1
    logic  aluSrcB;    // Immediate in place of rs2
    logic  resultImm;  // Immediate is the result (LUI)
    logic  regWrite;
  } ctrlET;

endpackage

`default_nettype wire

// File: immExtend.sv
/* Immediate generator for I-type and U-type formats */
`default_nettype none

module immExtend import ieuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic [31:7]     instr,
  input  immSrcT          immSrc,
  output logic [XLEN-1:0] imm
);

  // Signed views so that the size casts below sign-extend
  logic signed [11:0] iImm;
  logic signed [31:0] uImm;

  // I-type takes instr[31:20]
  assign iImm = instr[31:20];

  // U-type puts instr[31:12] on top of twelve zero bits
  assign uImm = {instr[31:12], 12'h000};

  always_comb begin
    case (immSrc)
      immU:    imm = XLEN'(uImm);
      default: imm = XLEN'(iImm);
    endcase
  end

  // Bits 11:7 hold rd in both formats and never reach the immediate

endmodule

`default_nettype wire

// File: intController.sv
/*
  Instruction decoder and control pipeline for Execute, Memory and
  Writeback
*/
`default_nettype none

module intController import ieuPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        instrValid,
  input  logic [31:0] instrD,
  output immSrcT      immSrcD,
  output ctrlET       ctrlE,
  output logic        regWriteM,
  output logic        regWriteW
);

  opcodeT     opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  logic       opFunct7Ok;
  ctrlET      ctrlD;

  assign opcode   = instrD[6:0];
  assign funct3   = instrD[14:12];
  assign funct7b5 = instrD[30];

  // OP only accepts funct7 of zero, or 0100000 for sub and sra
  assign opFunct7Ok = (instrD[31:25] == 7'b0000000) ||
                      (instrD[31:25] == 7'b0100000 &&
                       (funct3 == 3'b000 || funct3 == 3'b101));

  // funct3 picks the op and alt selects sub or sra
  function automatic aluOpT aluDecode(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return alt ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrlD   = '0;
    immSrcD = immI;
    case (opcode)
      opOp: begin
        ctrlD.aluOp    = aluDecode(funct3, funct7b5);
        ctrlD.regWrite = opFunct7Ok;
      end
      opOpImm: begin
        // No subi, so bit 30 only matters for right shifts
        ctrlD.aluOp    = aluDecode(funct3, funct7b5 && funct3 == 3'b101);
        ctrlD.aluSrcB  = 1'b1;
        ctrlD.regWrite = 1'b1;
      end
      opLui: begin
        immSrcD         = immU;
        ctrlD.resultImm = 1'b1;
        ctrlD.regWrite  = 1'b1;
      end
      opAuipc: begin
        immSrcD        = immU;
        ctrlD.aluOp    = aluAdd;
        ctrlD.aluSrcA  = 1'b1;
        ctrlD.aluSrcB  = 1'b1;
        ctrlD.regWrite = 1'b1;
      end
      default: ctrlD = '0;
    endcase
    // Empty slot travels as a bubble
    if (!instrValid) ctrlD.regWrite = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Control pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE     <= '0;
      regWriteM <= 1'b0;
      regWriteW <= 1'b0;
    end else begin
      ctrlE     <= ctrlD;
      regWriteM <= ctrlE.regWrite;
      regWriteW <= regWriteM;
    end
  end

endmodule

`default_nettype wire

// File: regFile.sv
/*
  Integer register file: 31 writable registers, x0 tied to zero,
  two combinational read ports with write-through
*/
`default_nettype none

module regFile import ieuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            we,
  input  regIdxT          rs1,
  input  regIdxT          rs2,
  input  regIdxT          rd,
  input  logic [XLEN-1:0] wd,
  output logic [XLEN-1:0] rd1,
  output logic [XLEN-1:0] rd2
);

  // No storage behind x0
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  // Write-through covers the Writeback to Decode path
  function automatic logic [XLEN-1:0] readPort(regIdxT idx);
    if (idx == '0) return '0;
    else if (we && idx == rd) return wd;
    else return regs[idx];
  endfunction

  always_comb rd1 = readPort(rs1);
  always_comb rd2 = readPort(rs2);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run tbIeu with Verilator, then scan the log for failures
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbIeu -f src.f -o simIeu > build.log 2>&1 &&
./obj_dir/simIeu > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
! grep -q "ERRORS FOUND" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: src.f
ieuPkg.sv
regFile.sv
immExtend.sv
alu.sv
intController.sv
hazardUnit.sv
datapath.sv
ieu.sv
tbClock.sv
tbIeu.sv

// File: tbClock.sv
/* Free-running testbench clock */
`default_nettype none

module tbClock #(
  parameter int Period = 10
) (
  output logic clk
);

  // Starts low so the first rising edge is at half a period
  initial clk = 1'b0;

  always #(Period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tbIeu.sv
/*
  Testbench for the integer execution unit: directed and random stimulus,
  an architectural register model and writeback checks
*/
`default_nettype none

module tbIeu import ieuPkg::*;;

  // Expected writeback with the cycle on which it must show
  typedef struct packed {
    regIdxT      rd;
    logic [31:0] data;
    int          cycle;
  } wbEntT;

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instrD;
  logic [31:0] pcD;
  logic        wbValid;
  regIdxT      wbRd;
  logic [31:0] wbData;

  logic [31:0] regs [32];
  logic [31:0] seed;
  wbEntT       expQ [$];
  string       nameQ [$];
  wbEntT       head;
  string       headName;
  int          cycle;
  int          checks;
  int          errors;
  int          waitCnt;

  tbClock #(.Period(10)) clkGen (.clk);

  ieu #(.XLEN(32)) UUT (
    .clk, .rstN, .instrValid, .instrD, .pcD, .wbValid, .wbRd, .wbData
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] encR(input logic [6:0] f7, input regIdxT rs2,
                                       input regIdxT rs1, input logic [2:0] f3,
                                       input regIdxT rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input regIdxT rs1,
                                       input logic [2:0] f3, input regIdxT rd);
    return {imm, rs1, f3, rd, opOpImm};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input regIdxT rd,
                                       input opcodeT op);
    return {imm, rd, op};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Architectural model
  //////////////////////////////////////////////////////////////////////

  // Returns 1 when the instruction writes back, with its result in res
  function automatic logic modelExec(input logic [31:0] ins, input logic [31:0] pc,
                                     output logic [31:0] res);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic        ok;
    op  = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    a   = regs[ins[19:15]];
    b   = (op == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : regs[ins[24:20]];
    ok  = 1'b1;
    res = '0;
    case (op)
      7'h37: res = {ins[31:12], 12'h000};
      7'h17: res = pc + {ins[31:12], 12'h000};
      7'h33, 7'h13: begin
        case (f3)
          3'd0: res = (op == 7'h33 && f7[5]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: res = (a < b) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: res = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: res = a | b;
          default: res = a & b;
        endcase
        // Register form only allows funct7 zero, or sub and sra
        if (op == 7'h33) ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Drive one Decode slot and queue what it should retire
  task automatic issue(input string name, input logic v, input logic [31:0] ins,
                       input logic [31:0] pc);
    logic [31:0] res;
    wbEntT       e;
    @(negedge clk);
    instrValid = v;
    instrD     = ins;
    pcD        = pc;
    if (v && modelExec(ins, pc, res)) begin
      // Writeback shows three rising edges after the slot is presented
      e = '{rd: ins[11:7], data: res, cycle: cycle + 3};
      expQ.push_back(e);
      nameQ.push_back(name);
      if (ins[11:7] != 5'd0) regs[ins[11:7]] = res;
    end
  endtask

  task automatic issueRandom();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    regIdxT      rd;
    regIdxT      rs1;
    regIdxT      rs2;
    seed = lcgNext(seed);
    r1   = seed;
    seed = lcgNext(seed);
    r2   = seed;
    seed = lcgNext(seed);
    r3   = seed;
    // Only x0 to x7 so that dependences are frequent
    rd   = {2'b00, r2[31:29]};
    rs1  = {2'b00, r2[28:26]};
    rs2  = {2'b00, r2[25:23]};
    case (r1[31:28])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
        issue("rand op", 1'b1, encR({1'b0, r1[27] & r1[26], 5'b0}, rs2, rs1, r2[22:20], rd),
              r3);
      4'd11: issue("rand lui", 1'b1, encU(r3[31:12], rd, opLui), r1);
      4'd12: issue("rand auipc", 1'b1, encU(r3[31:12], rd, opAuipc), {r1[29:0], 2'b00});
      4'd13: issue("rand idle", 1'b0, r3, r1);
      // Load and multiply encodings are outside the subset
      4'd14: issue("rand load", 1'b1, {r3[31:7], 7'b0000011}, r1);
      4'd15: issue("rand mul", 1'b1, encR(7'h01, rs2, rs1, r2[22:20], rd), r1);
      default: issue("rand op-imm", 1'b1, encI(r3[31:20], rs1, r2[22:20], rd), r1);
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Writeback checks, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (wbValid) begin
      checks++;
      assert (expQ.size() != 0) else begin
        $display("Unexpected writeback to x%0d at cycle %0d", wbRd, cycle);
        errors++;
      end
      if (expQ.size() != 0) begin
        head     = expQ.pop_front();
        headName = nameQ.pop_front();
        assert (head.cycle == cycle) else begin
          $display("Fail %s cycle: expected %0d actual %0d", headName, head.cycle, cycle);
          errors++;
        end
        assert (wbRd == head.rd) else begin
          $display("Fail %s rd: expected %0d actual %0d", headName, head.rd, wbRd);
          errors++;
        end
        assert (wbData == head.data) else begin
          $display("Fail %s data: expected %h actual %h", headName, head.data, wbData);
          errors++;
        end
      end
    end else if (expQ.size() != 0) begin
      assert (expQ[0].cycle > cycle) else begin
        $display("Writeback of %s did not arrive at cycle %0d", nameQ[0], cycle);
        errors++;
        void'(expQ.pop_front());
        void'(nameQ.pop_front());
      end
    end
  end

  initial begin
    rstN       = 1'b0;
    instrValid = 1'b0;
    instrD     = '0;
    pcD        = '0;
    cycle      = 0;
    checks     = 0;
    errors     = 0;
    seed       = 32'he050_29bb;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (16) @(negedge clk);
    rstN = 1'b1;

    // Invalid slots with live-looking instructions retire nothing
    issue("idle slot", 1'b0, encI(12'd7, 5'd0, 3'd0, 5'd1), 32'h0);
    issue("idle slot", 1'b0, encU(20'hfffff, 5'd2, opLui), 32'h0);

    // Extreme operands for compares and shifts
    issue("lui x1", 1'b1, encU(20'h80000, 5'd1, opLui), 32'h0);
    issue("addi x2", 1'b1, encI(12'hfff, 5'd0, 3'd0, 5'd2), 32'h0);
    issue("slt min", 1'b1, encR(7'h00, 5'd2, 5'd1, 3'd2, 5'd3), 32'h0);
    issue("sltu min", 1'b1, encR(7'h00, 5'd2, 5'd1, 3'd3, 5'd4), 32'h0);
    issue("slt swap", 1'b1, encR(7'h00, 5'd1, 5'd2, 3'd2, 5'd5), 32'h0);
    issue("sra 31", 1'b1, encR(7'h20, 5'd2, 5'd1, 3'd5, 5'd6), 32'h0);
    issue("srl 31", 1'b1, encR(7'h00, 5'd2, 5'd1, 3'd5, 5'd6), 32'h0);
    issue("sll 31", 1'b1, encR(7'h00, 5'd2, 5'd2, 3'd1, 5'd6), 32'h0);
    issue("slti min", 1'b1, encI(12'h800, 5'd1, 3'd2, 5'd5), 32'h0);
    issue("sltiu max", 1'b1, encI(12'h7ff, 5'd2, 3'd3, 5'd5), 32'h0);
    issue("srai 31", 1'b1, encI({7'h20, 5'd31}, 5'd1, 3'd5, 5'd6), 32'h0);
    issue("sub", 1'b1, encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd7), 32'h0);
    issue("auipc", 1'b1, encU(20'h12345, 5'd8, opAuipc), 32'h0000_1ff0);

    // Consumers at distance 1, 2 and 3
    issue("addi x8", 1'b1, encI(12'd100, 5'd0, 3'd0, 5'd8), 32'h0);
    issue("dist 1", 1'b1, encR(7'h00, 5'd0, 5'd8, 3'd0, 5'd9), 32'h0);
    issue("dist 2", 1'b1, encR(7'h00, 5'd8, 5'd0, 3'd0, 5'd10), 32'h0);
    issue("dist 3", 1'b1, encR(7'h00, 5'd8, 5'd8, 3'd0, 5'd11), 32'h0);

    // x0 write in flight must not forward
    issue("addi x0", 1'b1, encI(12'd5, 5'd0, 3'd0, 5'd0), 32'h0);
    issue("read x0", 1'b1, encR(7'h00, 5'd0, 5'd0, 3'd6, 5'd12), 32'h0);
    issue("xori x0", 1'b1, encI(12'd0, 5'd0, 3'd4, 5'd13), 32'h0);

    repeat (400) issueRandom();

    @(negedge clk);
    instrValid = 1'b0;
    waitCnt    = 0;
    while (expQ.size() != 0 && waitCnt < 50) begin
      @(negedge clk);
      waitCnt++;
    end
    if (expQ.size() != 0) begin
      $display("Timeout with %0d writebacks still outstanding", expQ.size());
      errors++;
    end

    $display("Writebacks checked %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
